//--- verilog.f
hdl/line_follower_pkg.sv
hdl/sensor_filter.sv
hdl/track_decoder.sv
hdl/speed_planner.sv
hdl/pwm_generator.sv
hdl/line_follower_top.sv
sim/line_follower_tb.sv

//--- Bender.yml
package:
  name: line_follower

sources:
  # package first, then the stages, then the top level
  - files:
      - hdl/line_follower_pkg.sv
      - hdl/sensor_filter.sv
      - hdl/track_decoder.sv
      - hdl/speed_planner.sv
      - hdl/pwm_generator.sv
      - hdl/line_follower_top.sv

  # testbench, top module line_follower_tb
  - target: simulation
    files:
      - sim/line_follower_tb.sv

//--- sim/line_follower_tb.sv
module line_follower_tb import line_follower_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FILTER_LEN     = 4;
    localparam int PWM_PERIOD     = 1024;   // high count equals duty
    localparam int RAMP_STEP      = 64;
    localparam int CLK_PERIOD     = 8;
    localparam int SEED           = 10600;
    localparam int MODE_LATENCY   = 2 + FILTER_LEN + 2;
    localparam int SETTLE_PERIODS = 12;     // full 750 swing at 64 per period
    localparam int GLITCH_LEN     = FILTER_LEN - 1;
    localparam int RAMP_WINDOWS   = 14;
    localparam int MARGIN_PERIODS = 40;     // reset, ramp phase and slack

    typedef struct packed {
        logic        en;
        logic [2:0]  pattern;
        bit          glitch;        // short pulse and then back to the held pattern
        track_mode_t mode;
        int          left;
        int          right;
    } entry_t;

    logic        clk;
    logic        reset;
    logic        enable;
    logic [2:0]  sensor;
    logic        pwm_left;
    logic        pwm_right;
    track_mode_t mode;

    int          errors;
    int          checks;
    entry_t      entries[$];
    logic [2:0]  held_pattern;

    line_follower_top #(
        .FILTER_LEN (FILTER_LEN),
        .PWM_PERIOD (PWM_PERIOD),
        .RAMP_STEP  (RAMP_STEP)
    ) dut_i (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .sensor    (sensor),
        .pwm_left  (pwm_left),
        .pwm_right (pwm_right),
        .mode      (mode)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input int actual, input int expected, input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR @ %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic add_entry(
        input logic        en,
        input logic [2:0]  pattern,
        input bit          glitch,
        input track_mode_t exp_mode,
        input int          exp_left,
        input int          exp_right
    );
        entry_t e;
        e.en      = en;
        e.pattern = pattern;
        e.glitch  = glitch;
        e.mode    = exp_mode;
        e.left    = exp_left;
        e.right   = exp_right;
        entries.push_back(e);
    endtask

    // pattern bits are {left, middle, right}
    task automatic build_entries();
        add_entry(1'b1, 3'b000, 1'b0, MODE_STOP, 0, 0);        // no side seen yet
        add_entry(1'b1, 3'b010, 1'b0, MODE_STRAIGHT, SPEED_STRAIGHT, SPEED_STRAIGHT);
        add_entry(1'b1, 3'b100, 1'b1, MODE_STRAIGHT, SPEED_STRAIGHT, SPEED_STRAIGHT);
        add_entry(1'b1, 3'b110, 1'b0, MODE_LEFT, SPEED_TURN_SLOW, SPEED_TURN_FAST);
        add_entry(1'b1, 3'b011, 1'b0, MODE_RIGHT, SPEED_TURN_FAST, SPEED_TURN_SLOW);
        add_entry(1'b1, 3'b100, 1'b0, MODE_SHARP_LEFT, SPEED_SHARP_SLOW, SPEED_SHARP_FAST);
        add_entry(1'b1, 3'b001, 1'b0, MODE_SHARP_RIGHT, SPEED_SHARP_FAST, SPEED_SHARP_SLOW);
        add_entry(1'b1, 3'b000, 1'b0, MODE_SHARP_RIGHT, SPEED_SHARP_FAST, SPEED_SHARP_SLOW);
        add_entry(1'b1, 3'b111, 1'b0, MODE_STRAIGHT, SPEED_STRAIGHT, SPEED_STRAIGHT);
        add_entry(1'b1, 3'b101, 1'b0, MODE_STRAIGHT, SPEED_STRAIGHT, SPEED_STRAIGHT);
        add_entry(1'b1, 3'b110, 1'b0, MODE_LEFT, SPEED_TURN_SLOW, SPEED_TURN_FAST);
        add_entry(1'b1, 3'b000, 1'b0, MODE_SHARP_LEFT, SPEED_SHARP_SLOW, SPEED_SHARP_FAST);
        add_entry(1'b0, 3'b010, 1'b0, MODE_STOP, 0, 0);        // motors off
        add_entry(1'b0, 3'b001, 1'b0, MODE_STOP, 0, 0);
        add_entry(1'b1, 3'b011, 1'b0, MODE_RIGHT, SPEED_TURN_FAST, SPEED_TURN_SLOW);
        add_entry(1'b1, 3'b000, 1'b1, MODE_RIGHT, SPEED_TURN_FAST, SPEED_TURN_SLOW);
        add_entry(1'b0, 3'b111, 1'b0, MODE_STOP, 0, 0);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic drive_inputs(input logic en, input logic [2:0] pattern);
        @(posedge clk);
        #1;
        enable = en;
        sensor = pattern;
    endtask

    // stops on the negedge where pwm_left is first seen high
    task automatic find_rise(output bit found);
        logic prev;
        found = 1'b0;
        @(negedge clk);
        prev = pwm_left;
        for (int n = 0; n < 2 * PWM_PERIOD && !found; n++) begin
            @(negedge clk);
            if (pwm_left && !prev) begin
                found = 1'b1;
            end
            prev = pwm_left;
        end
    endtask

    // first sample is taken at the current negedge
    task automatic count_window(output int hi_left, output int hi_right);
        hi_left  = 0;
        hi_right = 0;
        for (int k = 0; k < PWM_PERIOD; k++) begin
            if (k > 0) begin
                @(negedge clk);
            end
            hi_left  += int'(pwm_left);
            hi_right += int'(pwm_right);
        end
    endtask

    task automatic measure_period(output int hi_left, output int hi_right);
        bit found;
        find_rise(found);
        // without a rise the window sees a constant level for a whole period
        count_window(hi_left, hi_right);
    endtask

    // left duty must fall by at most RAMP_STEP per period after straight to sharp left
    task automatic run_ramp_test();
        int prev;
        int hi_left;
        int hi_right;
        int reached_at;
        bit found;
        drive_inputs(1'b1, 3'b010);
        held_pattern = 3'b010;
        wait_cycles(MODE_LATENCY);
        @(negedge clk);
        check_value(int'(mode), int'(MODE_STRAIGHT), "ramp start mode");
        wait_cycles(SETTLE_PERIODS * PWM_PERIOD);
        measure_period(prev, hi_right);
        check_value(prev, int'(SPEED_STRAIGHT), "ramp start left high count");
        drive_inputs(1'b1, 3'b100);
        held_pattern = 3'b100;
        find_rise(found);
        if (!found) begin
            errors++;
            $display("pwm_left never went high after the jump to sharp left");
        end else begin
            reached_at = -1;
            for (int w = 0; w < RAMP_WINDOWS; w++) begin
                if (w > 0) begin
                    @(negedge clk);     // windows back to back
                end
                count_window(hi_left, hi_right);
                check_value(int'(hi_left <= prev), 1,
                    $sformatf("ramp period %0d left rose %0d -> %0d", w, prev, hi_left));
                check_value(int'(prev - hi_left <= RAMP_STEP), 1,
                    $sformatf("ramp period %0d left step %0d -> %0d", w, prev, hi_left));
                if (hi_left == int'(SPEED_SHARP_SLOW) && reached_at < 0) begin
                    reached_at = w;
                end
                prev = hi_left;
            end
            check_value(int'(reached_at >= 0 && reached_at < SETTLE_PERIODS), 1,
                $sformatf("ramp reached sharp slow at period %0d", reached_at));
            check_value(prev, int'(SPEED_SHARP_SLOW), "ramp final left high count");
        end
    endtask

    initial begin
        entry_t e;
        int     jitter;
        int     settle;
        int     hi_left;
        int     hi_right;
        clk    = 1'b0;
        reset  = 1'b1;
        enable = 1'b0;
        sensor = 3'b000;
        errors = 0;
        checks = 0;
        void'($urandom(SEED));
        build_entries();
        held_pattern = 3'b000;
        wait_cycles(2);
        #1;
        reset = 1'b0;

        for (int i = 0; i < entries.size(); i++) begin
            e      = entries[i];
            jitter = $urandom_range(3, 0);
            wait_cycles(jitter);
            if (e.glitch) begin
                drive_inputs(e.en, e.pattern);
                wait_cycles(GLITCH_LEN - 1);
                drive_inputs(e.en, held_pattern);   // shorter than the filter
            end else begin
                drive_inputs(e.en, e.pattern);
                held_pattern = e.pattern;
            end
            wait_cycles(MODE_LATENCY);
            @(negedge clk);
            check_value(int'(mode), int'(e.mode), $sformatf("entry %0d mode", i));
            // a stop must reach the outputs within two periods
            settle = (e.mode == MODE_STOP) ? 1 : SETTLE_PERIODS;
            wait_cycles(settle * PWM_PERIOD);
            measure_period(hi_left, hi_right);
            check_value(hi_left, e.left, $sformatf("entry %0d left high count", i));
            check_value(hi_right, e.right, $sformatf("entry %0d right high count", i));
        end

        run_ramp_test();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // about 14 periods per table entry plus margin
    initial begin
        longint limit_ns;
        #1;
        limit_ns = (longint'(entries.size()) * 14 + MARGIN_PERIODS)
                   * PWM_PERIOD * CLK_PERIOD;
        #(limit_ns);
        $display("timeout, the run did not finish within %0d ns", limit_ns);
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- hdl/line_follower_top.sv
module line_follower_top import line_follower_pkg::*; #(
    parameter int FILTER_LEN = 16,
    parameter int PWM_PERIOD = 4000,    // 25 kHz at 100 MHz
    parameter int RAMP_STEP  = 32
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        enable,
    input  logic [2:0]  sensor,         // {left, middle, right}
    output logic        pwm_left,
    output logic        pwm_right,
    output track_mode_t mode
);

    logic [2:0]        sensor_clean;
    logic              period_start;
    logic [DUTY_W-1:0] duty_left;
    logic [DUTY_W-1:0] duty_right;

    sensor_filter #(
        .FILTER_LEN(FILTER_LEN)
    ) sensor_filter_i (
        .clk          (clk),
        .reset        (reset),
        .sensor       (sensor),
        .sensor_clean (sensor_clean)
    );

    track_decoder track_decoder_i (
        .clk          (clk),
        .reset        (reset),
        .enable       (enable),
        .sensor_clean (sensor_clean),
        .mode         (mode)
    );

    speed_planner #(
        .RAMP_STEP(RAMP_STEP)
    ) speed_planner_i (
        .clk          (clk),
        .reset        (reset),
        .period_start (period_start),
        .mode         (mode),
        .duty_left    (duty_left),
        .duty_right   (duty_right)
    );

    // left channel also provides the period timing
    pwm_generator #(
        .PWM_PERIOD(PWM_PERIOD)
    ) pwm_left_i (
        .clk          (clk),
        .reset        (reset),
        .duty         (duty_left),
        .pwm          (pwm_left),
        .period_start (period_start)
    );

    pwm_generator #(
        .PWM_PERIOD(PWM_PERIOD)
    ) pwm_right_i (
        .clk          (clk),
        .reset        (reset),
        .duty         (duty_right),
        .pwm          (pwm_right),
        .period_start ()                // runs in lockstep with the left one
    );

endmodule

//--- hdl/pwm_generator.sv
module pwm_generator import line_follower_pkg::*; #(
    parameter int PWM_PERIOD = 4000
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [DUTY_W-1:0] duty,
    output logic              pwm,
    output logic              period_start
);

    localparam int CNT_W  = $clog2(PWM_PERIOD);
    localparam int PROD_W = DUTY_W + CNT_W + 1;

    logic [CNT_W-1:0]  count;
    logic [CNT_W-1:0]  high_count;      // held for the whole period
    logic [CNT_W-1:0]  high_now;
    logic [PROD_W-1:0] duty_product;

    assign period_start = (count == '0);

    // scale duty to clock cycles, full scale 1024
    assign duty_product = PROD_W'(duty) * PROD_W'(PWM_PERIOD);
    assign high_now     = period_start ? CNT_W'(duty_product >> DUTY_W) : high_count;

    // pwm is registered, so it trails count by one cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count      <= '0;
            high_count <= '0;
            pwm        <= 1'b0;
        end else begin
            if (count == CNT_W'(PWM_PERIOD - 1)) begin
                count <= '0;
            end else begin
                count <= count + CNT_W'(1);
            end
            high_count <= high_now;     // loads only at period start
            pwm        <= (count < high_now);
        end
    end

endmodule

//--- hdl/speed_planner.sv
module speed_planner import line_follower_pkg::*; #(
    parameter int RAMP_STEP = 32
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              period_start,
    input  track_mode_t       mode,
    output logic [DUTY_W-1:0] duty_left,
    output logic [DUTY_W-1:0] duty_right
);

    localparam logic [DUTY_W-1:0] STEP = DUTY_W'(RAMP_STEP);

    logic [DUTY_W-1:0] target_left;
    logic [DUTY_W-1:0] target_right;

    // one ramp step from cur toward tgt, lands on tgt when close
    function automatic logic [DUTY_W-1:0] ramp_toward(
        input logic [DUTY_W-1:0] cur,
        input logic [DUTY_W-1:0] tgt
    );
        logic [DUTY_W-1:0] gap;
        if (tgt > cur) begin
            gap         = tgt - cur;
            ramp_toward = (gap > STEP) ? cur + STEP : tgt;
        end else begin
            gap         = cur - tgt;
            ramp_toward = (gap > STEP) ? cur - STEP : tgt;
        end
    endfunction

    // fixed speed table lookup
    always_comb begin
        case (mode)
            MODE_STRAIGHT: begin
                target_left  = SPEED_STRAIGHT;
                target_right = SPEED_STRAIGHT;
            end
            MODE_LEFT: begin            // inner wheel slower
                target_left  = SPEED_TURN_SLOW;
                target_right = SPEED_TURN_FAST;
            end
            MODE_RIGHT: begin
                target_left  = SPEED_TURN_FAST;
                target_right = SPEED_TURN_SLOW;
            end
            MODE_SHARP_LEFT: begin
                target_left  = SPEED_SHARP_SLOW;
                target_right = SPEED_SHARP_FAST;
            end
            MODE_SHARP_RIGHT: begin
                target_left  = SPEED_SHARP_FAST;
                target_right = SPEED_SHARP_SLOW;
            end
            default: begin              // stop
                target_left  = '0;
                target_right = '0;
            end
        endcase
    end

    // stepped once per pwm period to limit motor current surges
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            duty_left  <= '0;
            duty_right <= '0;
        end else if (mode == MODE_STOP) begin
            duty_left  <= '0;                   // stop skips the ramp
            duty_right <= '0;
        end else if (period_start) begin
            duty_left  <= ramp_toward(duty_left, target_left);
            duty_right <= ramp_toward(duty_right, target_right);
        end
    end

endmodule

//--- hdl/track_decoder.sv
module track_decoder import line_follower_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        enable,
    input  logic [2:0]  sensor_clean,
    output track_mode_t mode
);

    // side where the line was last seen
    typedef enum logic [1:0] {
        SIDE_NONE  = 2'd0,
        SIDE_LEFT  = 2'd1,
        SIDE_RIGHT = 2'd2
    } side_t;

    side_t       last_side;
    side_t       last_side_next;
    track_mode_t mode_next;

    // pattern bits are {left, middle, right}
    always_comb begin
        case (sensor_clean)
            3'b110, 3'b100: last_side_next = SIDE_LEFT;
            3'b011, 3'b001: last_side_next = SIDE_RIGHT;
            default:        last_side_next = last_side;     // keep memory
        endcase
    end

    always_comb begin
        case (sensor_clean)
            3'b010, 3'b111, 3'b101: mode_next = MODE_STRAIGHT;
            3'b110:                 mode_next = MODE_LEFT;
            3'b011:                 mode_next = MODE_RIGHT;
            3'b100:                 mode_next = MODE_SHARP_LEFT;
            3'b001:                 mode_next = MODE_SHARP_RIGHT;
            default: begin
                // line lost, swing back toward where it was last seen
                case (last_side)
                    SIDE_LEFT:  mode_next = MODE_SHARP_LEFT;
                    SIDE_RIGHT: mode_next = MODE_SHARP_RIGHT;
                    default:    mode_next = MODE_STOP;      // never seen yet
                endcase
            end
        endcase
        if (!enable) begin
            mode_next = MODE_STOP;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            last_side <= SIDE_NONE;
            mode      <= MODE_STOP;
        end else begin
            last_side <= last_side_next;
            mode      <= mode_next;
        end
    end

endmodule

//--- hdl/sensor_filter.sv
module sensor_filter #(
    parameter int FILTER_LEN = 16
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [2:0] sensor,
    output logic [2:0] sensor_clean
);

    localparam int CNT_W = $clog2(FILTER_LEN + 1);

    logic [2:0]       sync_q1;
    logic [2:0]       sync_q2;
    logic [CNT_W-1:0] stable_cnt [3];

    // two-flop synchronizer, sensors are asynchronous
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_q1 <= 3'b000;
            sync_q2 <= 3'b000;
        end else begin
            sync_q1 <= sensor;
            sync_q2 <= sync_q1;
        end
    end

    // each bit has its own stability counter
    // a bit flips after FILTER_LEN cycles of disagreement with its clean level
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sensor_clean <= 3'b000;
            for (int i = 0; i < 3; i++) begin
                stable_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (sync_q2[i] == sensor_clean[i]) begin
                    stable_cnt[i] <= '0;                    // agrees, restart
                end else if (stable_cnt[i] == CNT_W'(FILTER_LEN - 1)) begin
                    sensor_clean[i] <= sync_q2[i];          // stable long enough
                    stable_cnt[i]   <= '0;
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + CNT_W'(1);
                end
            end
        end
    end

endmodule

//--- hdl/line_follower_pkg.sv
package line_follower_pkg;

    // duty values are fractions of 1024
    localparam int DUTY_W = 10;

    // tracking mode, decoded from the floor sensors
    typedef enum logic [2:0] {
        MODE_STOP        = 3'd0,    // motors off
        MODE_STRAIGHT    = 3'd1,    // line centered
        MODE_LEFT        = 3'd2,    // line drifting left
        MODE_RIGHT       = 3'd3,    // line drifting right
        MODE_SHARP_LEFT  = 3'd4,    // only left sensor on line
        MODE_SHARP_RIGHT = 3'd5     // only right sensor on line
    } track_mode_t;

    // cruise speed, both wheels equal
    localparam logic [DUTY_W-1:0] SPEED_STRAIGHT = 10'd750;

    // gentle turn, the outer wheel runs faster
    localparam logic [DUTY_W-1:0] SPEED_TURN_SLOW = 10'd400;
    localparam logic [DUTY_W-1:0] SPEED_TURN_FAST = 10'd600;

    // sharp turn, wider split between the wheels
    localparam logic [DUTY_W-1:0] SPEED_SHARP_SLOW = 10'd300;
    localparam logic [DUTY_W-1:0] SPEED_SHARP_FAST = 10'd700;

    // left/right pairs per mode:
    //   MODE_STRAIGHT     SPEED_STRAIGHT   / SPEED_STRAIGHT
    //   MODE_LEFT         SPEED_TURN_SLOW  / SPEED_TURN_FAST
    //   MODE_RIGHT        SPEED_TURN_FAST  / SPEED_TURN_SLOW
    //   MODE_SHARP_LEFT   SPEED_SHARP_SLOW / SPEED_SHARP_FAST
    //   MODE_SHARP_RIGHT  SPEED_SHARP_FAST / SPEED_SHARP_SLOW
    //   MODE_STOP         0                / 0

endpackage
